//--- vlog.f
hdl/qspi_pkg.sv
hdl/qspi_reg_pkg.sv
hdl/qspi_sck_gen.sv
hdl/qspi_regs.sv
hdl/qspi_engine.sv
hdl/qspi_top.sv
tests/qspi_psram_model.sv
tests/tb_qspi.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_qspi -f vlog.f
./obj_dir/Vtb_qspi 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

//--- tests/tb_qspi.sv
`timescale 1ns/1ps

module tb_qspi
	import qspi_pkg::*, qspi_reg_pkg::*;
();

	localparam int num_transfers = 16;
	// command, address, longest wait, word data, start and end slack
	localparam int sck_per_transfer = 8 + 6 + 16 + 8 + 4;
	localparam int max_sck_period = 12;
	localparam int pulse_limit = sck_per_transfer * max_sck_period;
	localparam int watchdog_cycles = 2 * num_transfers * pulse_limit + 2000;

	logic clk;
	logic rst_n;
	logic [1:0] init_latency;
	logic read_req;
	logic write_req;
	qspi_req_t req;
	logic [31:0] read_data;
	logic read_valid;
	logic write_finish;
	logic io_we;
	logic [io_adr_w-1:0] io_wadr;
	logic [31:0] io_wdata;
	logic [io_adr_w-1:0] io_radr;
	logic io_radr_en;
	logic [31:0] io_rdata_in;
	logic [31:0] io_rdata;
	qspi_pins_t pins;
	logic [3:0] sio_i;
	logic [num_chips-1:0][3:0] model_sio;
	logic [num_chips-1:0] model_oe;
	logic [num_chips-1:0][3:0] model_lat;
	logic [num_chips-1:0] ce_seen;
	logic [31:0] rng_state;

	qspi_top qspi_top_inst (.*);

	qspi_psram_model psram0_inst (
		.sck(pins.sck),
		.ce_n(pins.ce_n[0]),
		.sio_i(pins.sio_o),
		.latency(model_lat[0]),
		.sio_o(model_sio[0]),
		.sio_oe(model_oe[0])
	);

	qspi_psram_model psram1_inst (
		.sck(pins.sck),
		.ce_n(pins.ce_n[1]),
		.sio_i(pins.sio_o),
		.latency(model_lat[1]),
		.sio_o(model_sio[1]),
		.sio_oe(model_oe[1])
	);

	qspi_psram_model psram2_inst (
		.sck(pins.sck),
		.ce_n(pins.ce_n[2]),
		.sio_i(pins.sio_o),
		.latency(model_lat[2]),
		.sio_o(model_sio[2]),
		.sio_oe(model_oe[2])
	);

	// only the selected chip drives the shared lines
	always_comb begin
		sio_i = 4'h0;
		for (int i = 0; i < num_chips; i++) begin
			if (!pins.ce_n[i] && model_oe[i]) begin
				sio_i = model_sio[i];
			end
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Error: watchdog expired before the tests finished");
		abort_run();
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [3:0] strap_expect(input logic [1:0] s);
		case (s)
			2'd0: return 4'd7;
			2'd1: return 4'd8;
			2'd2: return 4'd9;
			default: return 4'd6;
		endcase
	endfunction

	function automatic logic [7:0] mem_byte(input int chip, input logic [11:0] a);
		case (chip)
			1: return psram1_inst.mem[a];
			2: return psram2_inst.mem[a];
			default: return psram0_inst.mem[a];
		endcase
	endfunction

	// lowest address is the least significant byte
	function automatic logic [31:0] mem_word(input int chip, input logic [11:0] a);
		return {mem_byte(chip, a + 12'd3), mem_byte(chip, a + 12'd2),
			mem_byte(chip, a + 12'd1), mem_byte(chip, a)};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic reg_write(input logic [io_adr_w-1:0] adr, input logic [31:0] data);
		step();
		io_wadr = adr;
		io_wdata = data;
		io_we = 1'b1;
		step();
		io_we = 1'b0;
	endtask

	task automatic reg_read(input logic [io_adr_w-1:0] adr, output logic [31:0] data);
		step();
		io_radr = adr;
		io_radr_en = 1'b1;
		step();
		io_radr_en = 1'b0;
		data = io_rdata;
	endtask

	task automatic mem_transfer(input logic wr, input logic [25:0] adr, input qspi_size_t sz,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		logic got;
		step();
		req = '{wr: wr, size: sz, adr: adr, wdata: wdata};
		read_req = ~wr;
		write_req = wr;
		step();
		read_req = 1'b0;
		write_req = 1'b0;
		ce_seen = '0;
		got = 1'b0;
		n = 0;
		while (!got && n < pulse_limit) begin
			step();
			ce_seen = ce_seen | ~pins.ce_n;
			got = wr ? write_finish : read_valid;
			n++;
		end
		rdata = read_data;
		assert (got) else begin
			$display("Error: no %s completion pulse for address %h", wr ? "write" : "read", adr);
			abort_run();
		end
	endtask

	task automatic wait_sck_level(input logic level);
		int n;
		n = 0;
		while (pins.sck !== level && n < 4 * max_sck_period) begin
			step();
			n++;
		end
		assert (pins.sck === level) else begin
			$display("Error: sck stopped toggling");
			abort_run();
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] v;
		check_eq("reset ce_n", 32'(3'b111), 32'(pins.ce_n));
		check_eq("reset sio_en", 32'd0, 32'(pins.sio_en));
		reg_read(reg_sck_div, v);
		check_eq("reset sck_div", 32'd3, v);
		for (int i = 0; i < num_chips; i++) begin
			reg_read(14'(reg_latency0 + i), v);
			check_eq($sformatf("reset latency%0d", i), {28'd0, strap_expect(init_latency)}, v);
		end
	endtask

	task automatic test_reg_access();
		logic [31:0] v;
		reg_write(reg_latency0, 32'd4);
		reg_read(reg_latency0, v);
		check_eq("reg latency0 readback", 32'd4, v);
		model_lat[0] = 4'd4;
		// address outside the register map
		reg_read(14'h0123, v);
		check_eq("reg unaddressed read", io_rdata_in, v);
		step();
		check_eq("reg idle pass through", io_rdata_in, io_rdata);
	endtask

	task automatic test_word_chip0();
		logic [11:0] a;
		logic [31:0] w;
		logic [31:0] v;
		int pulses;
		a = 12'(lcg_next() >> 16) & 12'hffc;
		w = lcg_next();
		mem_transfer(1'b1, {14'd0, a}, sz_word, w, v);
		check_eq("word write memory", w, mem_word(0, a));
		mem_transfer(1'b0, {14'd0, a}, sz_word, 32'd0, v);
		check_eq("word read data", w, v);
		pulses = 0;
		repeat (64) begin
			step();
			if (read_valid) begin
				pulses++;
			end
		end
		check_eq("word read extra pulses", 32'd0, 32'(pulses));
	endtask

	task automatic test_byte_half();
		logic [11:0] a;
		logic [31:0] w;
		logic [31:0] rb;
		logic [31:0] rh;
		logic [31:0] v;
		logic [7:0] fill;
		a = 12'(lcg_next() >> 16) & 12'hff0;
		w = lcg_next();
		rb = lcg_next();
		rh = lcg_next();
		fill = mem_byte(0, a + 12'd4);
		mem_transfer(1'b1, {14'd0, a}, sz_word, w, v);
		mem_transfer(1'b1, {14'd0, a + 12'd2}, sz_half, rh, v);
		mem_transfer(1'b1, {14'd0, a + 12'd1}, sz_byte, rb, v);
		check_eq("partial write memory", {rh[15:0], rb[7:0], w[7:0]}, mem_word(0, a));
		mem_transfer(1'b0, {14'd0, a + 12'd1}, sz_byte, 32'd0, v);
		check_eq("byte read", {24'd0, rb[7:0]}, v);
		mem_transfer(1'b0, {14'd0, a + 12'd2}, sz_half, 32'd0, v);
		check_eq("half read", {16'd0, rh[15:0]}, v);
		// untouched byte keeps its fill value
		mem_transfer(1'b0, {14'd0, a + 12'd4}, sz_byte, 32'd0, v);
		check_eq("fill byte read", {24'd0, fill}, v);
	endtask

	task automatic test_chip_select();
		logic [11:0] a;
		logic [31:0] w;
		logic [31:0] v;
		logic [25:0] adr;
		reg_write(reg_latency1, 32'd3);
		reg_write(reg_latency2, 32'd6);
		model_lat[1] = 4'd3;
		model_lat[2] = 4'd6;
		for (int c = 1; c < num_chips; c++) begin
			a = 12'(lcg_next() >> 16) & 12'hffc;
			w = lcg_next();
			adr = {2'(c), 12'd0, a};
			mem_transfer(1'b1, adr, sz_word, w, v);
			check_eq($sformatf("chip%0d write enables", c), 32'(1 << c), 32'(ce_seen));
			check_eq($sformatf("chip%0d write memory", c), w, mem_word(c, a));
			mem_transfer(1'b0, adr, sz_word, 32'd0, v);
			check_eq($sformatf("chip%0d read enables", c), 32'(1 << c), 32'(ce_seen));
			check_eq($sformatf("chip%0d read data", c), w, v);
		end
	endtask

	task automatic test_sck_divider();
		logic [11:0] a;
		logic [31:0] w;
		logic [31:0] v;
		int high;
		reg_write(reg_sck_div, 32'd5);
		reg_read(reg_sck_div, v);
		check_eq("sck_div readback", 32'd5, v);
		wait_sck_level(1'b0);
		wait_sck_level(1'b1);
		high = 0;
		while (pins.sck && high < 4 * max_sck_period) begin
			high++;
			step();
		end
		check_eq("sck high time", 32'd6, 32'(high));
		a = 12'(lcg_next() >> 16) & 12'hffc;
		w = lcg_next();
		mem_transfer(1'b1, {14'd0, a}, sz_word, w, v);
		mem_transfer(1'b0, {14'd0, a}, sz_word, 32'd0, v);
		check_eq("slow sck word read", w, v);
	endtask

	initial begin
		rng_state = 32'hffaa_6b8a;
		rst_n = 1'b0;
		init_latency = 2'd2;
		read_req = 1'b0;
		write_req = 1'b0;
		req = '0;
		io_we = 1'b0;
		io_wadr = '0;
		io_wdata = '0;
		io_radr = '0;
		io_radr_en = 1'b0;
		io_rdata_in = 32'h5eed_c0de;
		model_lat = {num_chips{strap_expect(2'd2)}};
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// strap preset lands on the second clock
		step();
		step();
		test_reset_values();
		test_reg_access();
		test_word_chip0();
		test_byte_half();
		test_chip_select();
		test_sck_divider();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- tests/qspi_psram_model.sv
`timescale 1ns/1ps

module qspi_psram_model
	import qspi_pkg::*;
(
	input  logic sck,
	input  logic ce_n,
	input  logic [3:0] sio_i,
	input  logic [3:0] latency,
	output logic [3:0] sio_o,
	output logic sio_oe
);

	localparam int mem_size = 4096;

	logic [7:0] mem [0:mem_size-1];
	logic [7:0] cmd;
	logic [23:0] adr;
	logic [11:0] ptr;
	logic [3:0] hi_nib;
	int edges;

	// fill pattern uses every address bit
	initial begin
		for (int i = 0; i < mem_size; i++) begin
			mem[i] = 8'(i ^ (i >> 4) ^ 8'ha5);
		end
	end

	// sck is low when ce_n falls, so a low sck marks a new transaction
	always @(posedge sck or negedge ce_n) begin
		if (!sck) begin
			edges = 0;
		end else if (!ce_n) begin
			if (edges < 8) begin
				cmd = {cmd[6:0], sio_i[0]};
			end else if (edges < 8 + adr_nibbles) begin
				adr = {adr[19:0], sio_i};
				ptr = adr[11:0];
			end else if (cmd == cmd_write_quad) begin
				// first data edge is even, high nibble first
				if (edges[0] == 1'b0) begin
					hi_nib = sio_i;
				end else begin
					mem[ptr] = {hi_nib, sio_i};
					ptr = ptr + 12'd1;
				end
			end
			edges = edges + 1;
		end
	end

	// read data goes out after the falling edge, latency+1 wait clocks
	always @(negedge sck or posedge ce_n) begin
		int n;
		logic [7:0] rd_byte;
		if (ce_n || cmd != cmd_read_quad || edges < 15 + int'(latency)) begin
			sio_oe = 1'b0;
		end else begin
			n = edges - 15 - int'(latency);
			rd_byte = mem[12'(int'(adr[11:0]) + n / 2)];
			sio_o = n[0] ? rd_byte[3:0] : rd_byte[7:4];
			sio_oe = 1'b1;
		end
	end

endmodule

//--- hdl/qspi_top.sv
`timescale 1ns/1ps

module qspi_top
	import qspi_pkg::*, qspi_reg_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] init_latency,
	input  logic read_req,
	input  logic write_req,
	input  qspi_req_t req,
	output logic [31:0] read_data,
	output logic read_valid,
	output logic write_finish,
	input  logic io_we,
	input  logic [io_adr_w-1:0] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic [io_adr_w-1:0] io_radr,
	input  logic io_radr_en,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output qspi_pins_t pins,
	input  logic [3:0] sio_i
);

	qspi_cfg_t cfg;
	logic sck;
	logic rise;
	logic fall;

	qspi_sck_gen qspi_sck_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sck_div(cfg.sck_div),
		.sck(sck),
		.rise(rise),
		.fall(fall)
	);

	qspi_regs qspi_regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.init_latency(init_latency),
		.io_we(io_we),
		.io_wadr(io_wadr),
		.io_wdata(io_wdata),
		.io_radr(io_radr),
		.io_radr_en(io_radr_en),
		.io_rdata_in(io_rdata_in),
		.io_rdata(io_rdata),
		.cfg(cfg)
	);

	qspi_engine qspi_engine_inst (
		.clk(clk),
		.rst_n(rst_n),
		.read_req(read_req),
		.write_req(write_req),
		.req(req),
		.cfg(cfg),
		.sck(sck),
		.rise(rise),
		.fall(fall),
		.sio_i(sio_i),
		.pins(pins),
		.read_data(read_data),
		.read_valid(read_valid),
		.write_finish(write_finish)
	);

endmodule

//--- hdl/qspi_engine.sv
`timescale 1ns/1ps

module qspi_engine
	import qspi_pkg::*, qspi_reg_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic read_req,
	input  logic write_req,
	input  qspi_req_t req,
	input  qspi_cfg_t cfg,
	input  logic sck,
	input  logic rise,
	input  logic fall,
	input  logic [3:0] sio_i,
	output qspi_pins_t pins,
	output logic [31:0] read_data,
	output logic read_valid,
	output logic write_finish
);

	qspi_req_t req_q;
	qspi_state_t state;
	qspi_state_t state_nxt;
	logic pending;
	logic accept;
	logic done;
	logic [3:0] cnt;
	logic [3:0] cnt_nxt;
	logic [1:0] sel;
	logic [3:0] latency;
	logic [2:0] nib_last;
	logic [2:0] nib_idx;
	logic [2:0] wnib_sel;
	logic [7:0] cmd_byte;
	logic [3:0] adr_nib;
	logic [3:0] wdat_nib;
	logic [3:0] sio_nxt;
	logic sio_en_nxt;
	logic [num_chips-1:0] ce_n_nxt;
	logic [num_chips-1:0] ce_n_q;
	logic [3:0] sio_q;
	logic sio_en_q;
	logic [3:0] sync0;
	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [31:0] shift;
	logic [31:0] rd_word;

	assign accept = (read_req | write_req) & ~pending & (state == st_idle);

	// strobe decides direction
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
			req_q.wr <= write_req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (fall && state == st_idle) begin
			pending <= 1'b0;
		end
	end

	assign sel = req_q.adr[25:24];

	always_comb begin
		case (sel)
			2'd1: latency = cfg.latency[1];
			2'd2: latency = cfg.latency[2];
			default: latency = cfg.latency[0];
		endcase
	end

	// nibble count and little-endian reorder per size
	always_comb begin
		case (req_q.size)
			sz_word: begin
				nib_last = 3'd7;
				rd_word = {shift[7:0], shift[15:8], shift[23:16], shift[31:24]};
			end
			sz_half: begin
				nib_last = 3'd3;
				rd_word = {16'd0, shift[7:0], shift[15:8]};
			end
			default: begin
				nib_last = 3'd1;
				rd_word = {24'd0, shift[7:0]};
			end
		endcase
	end

	always_comb begin
		state_nxt = state;
		cnt_nxt = cnt - 4'd1;
		done = 1'b0;
		case (state)
			st_idle: begin
				cnt_nxt = 4'd7;
				if (pending) begin
					state_nxt = st_cmd;
				end
			end
			st_cmd: if (cnt == 4'd0) begin
				state_nxt = st_adr;
				cnt_nxt = 4'(adr_nibbles - 1);
			end
			st_adr: if (cnt == 4'd0) begin
				state_nxt = req_q.wr ? st_wdat : st_rdwait;
				cnt_nxt = req_q.wr ? {1'b0, nib_last} : latency;
			end
			st_rdwait: if (cnt == 4'd0) begin
				state_nxt = st_rddat;
				cnt_nxt = {1'b0, nib_last};
			end
			st_wdat, st_rddat: if (cnt == 4'd0) begin
				state_nxt = st_idle;
				done = 1'b1;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt <= 4'd0;
		end else if (fall) begin
			state <= state_nxt;
			cnt <= cnt_nxt;
		end
	end

	// command msb first on sio[0]
	assign cmd_byte = req_q.wr ? cmd_write_quad : cmd_read_quad;
	assign adr_nib = req_q.adr[{cnt[2:0], 2'b00} +: 4];

	// lowest byte first, high nibble first
	assign nib_idx = nib_last - cnt[2:0];
	assign wnib_sel = {nib_idx[2:1], ~nib_idx[0]};
	assign wdat_nib = req_q.wdata[{wnib_sel, 2'b00} +: 4];

	always_comb begin
		case (state)
			st_cmd: sio_nxt = {3'b000, cmd_byte[cnt[2:0]]};
			st_adr: sio_nxt = adr_nib;
			st_wdat: sio_nxt = wdat_nib;
			default: sio_nxt = 4'd0;
		endcase
	end

	assign sio_en_nxt = (state == st_cmd) | (state == st_adr) | (state == st_wdat);
	assign ce_n_nxt = (state == st_idle) ? '1 : ~(num_chips'(1) << sel);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ce_n_q <= '1;
			sio_q <= 4'd0;
			sio_en_q <= 1'b0;
		end else begin
			ce_n_q <= ce_n_nxt;
			sio_q <= sio_nxt;
			sio_en_q <= sio_en_nxt;
		end
	end

	assign pins = '{sck: sck, ce_n: ce_n_q, sio_o: sio_q, sio_en: sio_en_q};

	// metastability chain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync0 <= 4'd0;
			sync1 <= 4'd0;
			sync2 <= 4'd0;
		end else begin
			sync0 <= sio_i;
			sync1 <= sync0;
			sync2 <= sync1;
		end
	end

	always_ff @(posedge clk) begin
		if (rise && state == st_rddat) begin
			shift <= {shift[27:0], sync2};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_valid <= 1'b0;
			write_finish <= 1'b0;
			read_data <= 32'd0;
		end else begin
			read_valid <= fall & done & ~req_q.wr;
			write_finish <= fall & done & req_q.wr;
			if (fall && done && !req_q.wr) begin
				read_data <= rd_word;
			end
		end
	end

	a_req_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(read_req && write_req));

	// size 3 has no encoding
	a_size_valid: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (req.size != 2'd3));

	a_chip_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state != st_idle) |-> (sel != 2'd3));

endmodule

//--- hdl/qspi_regs.sv
`timescale 1ns/1ps

module qspi_regs
	import qspi_reg_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] init_latency,
	input  logic io_we,
	input  logic [io_adr_w-1:0] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic [io_adr_w-1:0] io_radr,
	input  logic io_radr_en,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output qspi_cfg_t cfg
);

	logic [3:0] wsel;
	logic [3:0] rsel;
	logic [3:0] rsel_q;
	logic [1:0] preset_sr;
	logic preset;

	assign wsel = {
		io_we & (io_wadr == reg_sck_div),
		io_we & (io_wadr == reg_latency2),
		io_we & (io_wadr == reg_latency1),
		io_we & (io_wadr == reg_latency0)
	};

	assign rsel = {
		io_radr_en & (io_radr == reg_sck_div),
		io_radr_en & (io_radr == reg_latency2),
		io_radr_en & (io_radr == reg_latency1),
		io_radr_en & (io_radr == reg_latency0)
	};

	// strap load once, second clock out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			preset_sr <= 2'b11;
		end else begin
			preset_sr <= {preset_sr[0], 1'b0};
		end
	end

	assign preset = preset_sr[1] & ~preset_sr[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.sck_div <= sck_div_reset;
			cfg.latency <= '0;
		end else begin
			for (int i = 0; i < $size(cfg.latency); i++) begin
				if (preset) begin
					cfg.latency[i] <= strap_latency[init_latency];
				end else if (wsel[i]) begin
					cfg.latency[i] <= io_wdata[3:0];
				end
			end
			if (wsel[3]) begin
				cfg.sck_div <= io_wdata[9:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsel_q <= 4'b0000;
		end else begin
			rsel_q <= rsel;
		end
	end

	// chained read, pass through when not addressed
	always_comb begin
		if (rsel_q[0]) begin
			io_rdata = {28'd0, cfg.latency[0]};
		end else if (rsel_q[1]) begin
			io_rdata = {28'd0, cfg.latency[1]};
		end else if (rsel_q[2]) begin
			io_rdata = {28'd0, cfg.latency[2]};
		end else if (rsel_q[3]) begin
			io_rdata = {22'd0, cfg.sck_div};
		end else begin
			io_rdata = io_rdata_in;
		end
	end

	// a latency write under the strap preset would be lost
	a_preset_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		preset |-> !(|wsel[2:0]));

endmodule

//--- hdl/qspi_sck_gen.sv
`timescale 1ns/1ps

module qspi_sck_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic [9:0] sck_div,
	output logic sck,
	output logic rise,
	output logic fall
);

	logic [9:0] cnt;
	logic sck_d;
	logic half;

	// >= so a smaller divider written mid-count does not run to wrap
	assign half = (cnt >= sck_div);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 10'd0;
		end else if (half) begin
			cnt <= 10'd0;
		end else begin
			cnt <= cnt + 10'd1;
		end
	end

	// sck idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck <= 1'b1;
			sck_d <= 1'b1;
		end else begin
			if (half) begin
				sck <= ~sck;
			end
			sck_d <= sck;
		end
	end

	assign rise = sck & ~sck_d;
	assign fall = ~sck & sck_d;

	// the read path needs a half period of at least three clocks
	a_sck_div_min: assert property (@(posedge clk) disable iff (!rst_n)
		sck_div >= 10'd2);

endmodule

//--- hdl/qspi_reg_pkg.sv
package qspi_reg_pkg;

	localparam int io_adr_w = 14;

	// word addresses on the i/o bus
	localparam logic [io_adr_w-1:0] reg_latency0 = 14'h3d00;
	localparam logic [io_adr_w-1:0] reg_latency1 = 14'h3d01;
	localparam logic [io_adr_w-1:0] reg_latency2 = 14'h3d02;
	localparam logic [io_adr_w-1:0] reg_sck_div = 14'h3d03;

	localparam logic [9:0] sck_div_reset = 10'd3;

	// strap 0..3 gives 7, 8, 9, 6 wait clocks
	localparam logic [3:0][3:0] strap_latency = {4'd6, 4'd9, 4'd8, 4'd7};

	typedef struct packed {
		logic [9:0] sck_div;
		logic [2:0][3:0] latency;
	} qspi_cfg_t;

endpackage

//--- hdl/qspi_pkg.sv
package qspi_pkg;

	localparam int num_chips = 3;
	localparam int adr_nibbles = 6;

	localparam logic [7:0] cmd_read_quad = 8'heb;
	localparam logic [7:0] cmd_write_quad = 8'h38;

	typedef enum logic [1:0] {
		sz_byte = 2'd0,
		sz_half = 2'd1,
		sz_word = 2'd2
	} qspi_size_t;

	// one cpu request, 61 bits
	typedef struct packed {
		logic wr;
		qspi_size_t size;
		logic [25:0] adr;
		logic [31:0] wdata;
	} qspi_req_t;

	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_cmd = 3'd1,
		st_adr = 3'd2,
		st_wdat = 3'd3,
		st_rdwait = 3'd4,
		st_rddat = 3'd5
	} qspi_state_t;

	// pad side, tristate lives outside
	typedef struct packed {
		logic sck;
		logic [num_chips-1:0] ce_n;
		logic [3:0] sio_o;
		logic sio_en;
	} qspi_pins_t;

endpackage
